//--- Bender.yml
package:
  name: intc

sources:
  - files:
      - hdl/intc_pkg.sv
      - hdl/int_source_reg.sv
      - hdl/int_sequencer.sv
      - hdl/fetch_pc.sv
      - hdl/intc_top.sv
  - target: test
    files:
      - test/imem_model.sv
      - test/tb_intc.sv

//--- hdl/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc (
	input  logic                clk,
	input  logic                rst,
	input  intc_pkg::redirect_t redirect,
	input  logic                take_branch,
	input  logic [31:0]         branch_pc,
	input  logic                hold,
	output logic [31:0]         pc
);

	logic [31:0] pc_next;
	logic [31:0] pc_inc;

	assign pc_inc = pc + 32'd4;

	// Redirect beats branch, branch beats stall
	always_comb begin
		if (redirect.valid) begin
			pc_next = redirect.target;
		end else if (take_branch) begin
			pc_next = branch_pc;
		end else if (hold) begin
			pc_next = pc;
		end else begin
			pc_next = pc_inc;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= intc_pkg::vec_reset;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

//--- hdl/int_sequencer.sv
`timescale 1ns/1ps

module int_sequencer #(
	parameter int FILL_CYCLES  = 3,
	parameter int DRAIN_CYCLES = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  intc_pkg::int_status_t  status,
	output logic                   clr_spart,
	output logic                   clr_spu,
	input  logic [31:0]            pc_curr,
	input  logic                   take_branch,
	input  logic [31:0]            branch_pc,
	input  logic [31:0]            instruction,
	output intc_pkg::redirect_t    redirect,
	output logic                   int_wait,
	output logic                   int_run,
	output logic                   int_done,
	output logic [31:0]            pc_resume
);

	// One counter serves both the fill wait and the drain
	localparam int CNT_MAX = (FILL_CYCLES > DRAIN_CYCLES) ? FILL_CYCLES : DRAIN_CYCLES;
	localparam int CW = $clog2(CNT_MAX + 2);
	localparam logic [CW-1:0] FILL_LAST  = CW'(FILL_CYCLES - 1);
	localparam logic [CW-1:0] DRAIN_LAST = CW'(DRAIN_CYCLES);

	typedef enum logic [3:0] {
		st_rst0,
		st_rst1,
		st_idle,
		st_vec,
		st_fetch,
		st_fill,
		st_run,
		st_handler,
		st_drain
	} state_t;

	state_t          state;
	state_t          next_state;
	logic [2:0]      src_q;
	logic [2:0]      src_d;
	logic            src_set;
	logic [31:0]     handler_q;
	logic            handler_set;
	logic            resume_set;
	logic [CW-1:0]   cnt;
	logic            cnt_clr;
	logic            is_reti;
	logic            take_spart;
	logic            take_spu;

	assign is_reti = (instruction[31:26] == intc_pkg::op_reti);

	// SPART has priority over SPU
	assign take_spart = status.spart_pend & status.spart_en;
	assign take_spu   = ~take_spart & status.spu_pend & status.spu_en;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_rst0;
		end else begin
			state <= next_state;
		end
	end

	// Source of the interrupt being serviced
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			src_q <= intc_pkg::src_none;
		end else if (src_set) begin
			src_q <= src_d;
		end
	end

	// Handler address read from the vector word
	always_ff @(posedge clk) begin
		if (handler_set) begin
			handler_q <= instruction;
		end
	end

	// Return address that follows any branch resolved while vectoring
	always_ff @(posedge clk) begin
		if (resume_set) begin
			pc_resume <= take_branch ? branch_pc : pc_curr;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
		end else if (cnt_clr) begin
			cnt <= '0;
		end else if (state == st_fill || state == st_drain) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_comb begin
		next_state      = state;
		src_d           = intc_pkg::src_none;
		src_set         = 1'b0;
		handler_set     = 1'b0;
		resume_set      = 1'b0;
		cnt_clr         = 1'b0;
		clr_spart       = 1'b0;
		clr_spu         = 1'b0;
		int_wait        = 1'b0;
		int_run         = 1'b0;
		int_done        = 1'b0;
		redirect.valid  = 1'b0;
		redirect.target = handler_q;

		unique case (state)
			st_rst0: begin
				redirect.valid  = 1'b1;
				redirect.target = intc_pkg::vec_reset;
				int_wait        = 1'b1;
				next_state      = st_rst1;
			end
			st_rst1: begin
				handler_set = 1'b1;
				int_wait    = 1'b1;
				next_state  = st_run;
			end
			st_idle: begin
				if (take_spart || take_spu) begin
					src_d      = take_spart ? intc_pkg::src_spart : intc_pkg::src_spu;
					src_set    = 1'b1;
					clr_spart  = take_spart;
					clr_spu    = take_spu;
					resume_set = 1'b1;
					int_wait   = 1'b1;
					next_state = st_vec;
				end
			end
			st_vec: begin
				redirect.valid  = 1'b1;
				redirect.target = (src_q == intc_pkg::src_spart) ?
					intc_pkg::vec_spart : intc_pkg::vec_spu;
				resume_set      = take_branch;
				int_wait        = 1'b1;
				next_state      = st_fetch;
			end
			st_fetch: begin
				// PC sits on the vector word now
				handler_set = 1'b1;
				cnt_clr     = 1'b1;
				resume_set  = take_branch;
				int_wait    = 1'b1;
				next_state  = (FILL_CYCLES == 0) ? st_run : st_fill;
			end
			st_fill: begin
				resume_set = take_branch;
				int_wait   = 1'b1;
				if (cnt == FILL_LAST) begin
					next_state = st_run;
				end
			end
			st_run: begin
				int_run        = 1'b1;
				redirect.valid = 1'b1;
				// Reset vectoring has no source and no RETI to wait for
				next_state = (src_q == intc_pkg::src_none) ? st_idle : st_handler;
			end
			st_handler: begin
				if (is_reti) begin
					cnt_clr    = 1'b1;
					int_wait   = 1'b1;
					next_state = st_drain;
				end
			end
			st_drain: begin
				if (take_branch) begin
					next_state = st_handler;
				end else if (cnt == DRAIN_LAST) begin
					int_done        = 1'b1;
					redirect.valid  = 1'b1;
					redirect.target = pc_resume;
					next_state      = st_idle;
				end else begin
					int_wait = 1'b1;
				end
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

endmodule

//--- hdl/int_source_reg.sv
`timescale 1ns/1ps

module int_source_reg (
	input  logic        clk,
	input  logic        rst,
	input  logic        hs_req,
	output logic        hs_ack,
	input  logic [31:0] instruction,
	input  logic        en_bit,
	input  logic        clr,
	output logic        pending,
	output logic        enabled
);

	logic capture;
	logic inten_wr;

	// A new request is seen only while ack is still low
	assign capture = hs_req & ~hs_ack;

	assign inten_wr = (instruction[31:26] == intc_pkg::op_inten);

	// Ack rises on capture and stays up until the source drops req
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hs_ack <= 1'b0;
		end else if (capture) begin
			hs_ack <= 1'b1;
		end else if (!hs_req) begin
			hs_ack <= 1'b0;
		end
	end

	// Set wins over clear, so a request in the accept cycle is not lost
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (capture) begin
			pending <= 1'b1;
		end else if (clr) begin
			pending <= 1'b0;
		end
	end

	// Enable comes out of reset set and follows INTEN instructions
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			enabled <= 1'b1;
		end else if (inten_wr) begin
			enabled <= en_bit;
		end
	end

endmodule

//--- hdl/intc_pkg.sv
package intc_pkg;

	// Opcodes sit in instruction bits 31 to 26
	localparam logic [5:0] op_inten = 6'b111111;
	localparam logic [5:0] op_reti  = 6'b111110;

	// Interrupt source codes held by the sequencer
	localparam logic [2:0] src_none  = 3'd0;
	localparam logic [2:0] src_spart = 3'd1;
	localparam logic [2:0] src_spu   = 3'd2;

	// Each vector word holds the address of its handler
	localparam logic [31:0] vec_reset = 32'h0000_0000;
	localparam logic [31:0] vec_spart = 32'h0000_0008;
	localparam logic [31:0] vec_spu   = 32'h0000_0004;

	// Four-phase request/acknowledge pair of one source
	typedef struct packed {
		logic req;
		logic ack;
	} int_hs_t;

	// Fetch redirect from the sequencer
	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

	// Pending and enable bits of both sources
	typedef struct packed {
		logic spart_pend;
		logic spart_en;
		logic spu_pend;
		logic spu_en;
	} int_status_t;

endpackage

//--- hdl/intc_top.sv
`timescale 1ns/1ps

module intc_top #(
	parameter int FILL_CYCLES  = 3,
	parameter int DRAIN_CYCLES = 4
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        spart_hs_req,
	output logic        spart_hs_ack,
	input  logic        spu_hs_req,
	output logic        spu_hs_ack,
	input  logic [31:0] instruction,
	input  logic        take_branch,
	input  logic [31:0] branch_pc,
	output logic [31:0] pc,
	output logic        int_wait,
	output logic        int_run,
	output logic        int_done,
	output logic [31:0] pc_resume
);

	intc_pkg::int_hs_t     spart_hs;
	intc_pkg::int_hs_t     spu_hs;
	intc_pkg::int_status_t status;
	intc_pkg::redirect_t   redirect;
	logic                  clr_spart;
	logic                  clr_spu;

	assign spart_hs.req = spart_hs_req;
	assign spart_hs_ack = spart_hs.ack;
	assign spu_hs.req   = spu_hs_req;
	assign spu_hs_ack   = spu_hs.ack;

	// INTEN bit 2 enables SPART
	int_source_reg i_spart_src (
		.clk         (clk),
		.rst         (rst),
		.hs_req      (spart_hs.req),
		.hs_ack      (spart_hs.ack),
		.instruction (instruction),
		.en_bit      (instruction[2]),
		.clr         (clr_spart),
		.pending     (status.spart_pend),
		.enabled     (status.spart_en)
	);

	// INTEN bit 1 enables SPU
	int_source_reg i_spu_src (
		.clk         (clk),
		.rst         (rst),
		.hs_req      (spu_hs.req),
		.hs_ack      (spu_hs.ack),
		.instruction (instruction),
		.en_bit      (instruction[1]),
		.clr         (clr_spu),
		.pending     (status.spu_pend),
		.enabled     (status.spu_en)
	);

	int_sequencer #(
		.FILL_CYCLES  (FILL_CYCLES),
		.DRAIN_CYCLES (DRAIN_CYCLES)
	) i_int_sequencer (
		.clk         (clk),
		.rst         (rst),
		.status      (status),
		.clr_spart   (clr_spart),
		.clr_spu     (clr_spu),
		.pc_curr     (pc),
		.take_branch (take_branch),
		.branch_pc   (branch_pc),
		.instruction (instruction),
		.redirect    (redirect),
		.int_wait    (int_wait),
		.int_run     (int_run),
		.int_done    (int_done),
		.pc_resume   (pc_resume)
	);

	// Fetch stalls whenever the sequencer asks for a wait
	fetch_pc i_fetch_pc (
		.clk         (clk),
		.rst         (rst),
		.redirect    (redirect),
		.take_branch (take_branch),
		.branch_pc   (branch_pc),
		.hold        (int_wait),
		.pc          (pc)
	);

endmodule

//--- test/imem_model.sv
`timescale 1ns/1ps

module imem_model (
	input  logic [31:0] addr,
	output logic [31:0] data
);

	// 4096 words picked by byte address bits 13 to 2
	logic [31:0] mem [0:4095];

	// Combinational read of the word at the current PC
	assign data = mem[addr[13:2]];

	// Each word gets its own index; opcode bits stay zero so every word is a NOP
	task fill_nops;
		for (int i = 0; i < 4096; i++) begin
			mem[i] = 32'(i);
		end
	endtask

	task write_word(input logic [31:0] byte_addr, input logic [31:0] value);
		mem[byte_addr[13:2]] = value;
	endtask

endmodule

//--- test/tb_intc.sv
`timescale 1ns/1ps

module tb_intc;

	localparam int FILL_CYCLES  = 3;
	localparam int DRAIN_CYCLES = 4;
	localparam int max_cycles   = 6 * 200;

	// Memory map of the test program
	localparam logic [31:0] main_addr   = 32'h0000_0100;
	localparam logic [31:0] spart_isr   = 32'h0000_0800;
	localparam logic [31:0] spu_isr     = 32'h0000_0C00;
	localparam logic [31:0] spart_reti  = 32'h0000_0810;
	localparam logic [31:0] spu_reti    = 32'h0000_0C10;
	localparam logic [31:0] mask_spu    = 32'h0000_0040;
	localparam logic [31:0] unmask_all  = 32'h0000_0080;
	localparam logic [31:0] branch_dest = 32'h0000_0500;

	logic        clk;
	logic        rst;
	logic        spart_hs_req;
	logic        spart_hs_ack;
	logic        spu_hs_req;
	logic        spu_hs_ack;
	logic [31:0] instruction;
	logic        take_branch;
	logic [31:0] branch_pc;
	logic [31:0] pc;
	logic        int_wait;
	logic        int_run;
	logic        int_done;
	logic [31:0] pc_resume;
	logic [31:0] resume_a;
	int          cycle_cnt;
	integer      seed;

	intc_top #(
		.FILL_CYCLES  (FILL_CYCLES),
		.DRAIN_CYCLES (DRAIN_CYCLES)
	) i_intc_top (
		.clk          (clk),
		.rst          (rst),
		.spart_hs_req (spart_hs_req),
		.spart_hs_ack (spart_hs_ack),
		.spu_hs_req   (spu_hs_req),
		.spu_hs_ack   (spu_hs_ack),
		.instruction  (instruction),
		.take_branch  (take_branch),
		.branch_pc    (branch_pc),
		.pc           (pc),
		.int_wait     (int_wait),
		.int_run      (int_run),
		.int_done     (int_done),
		.pc_resume    (pc_resume)
	);

	imem_model i_imem (
		.addr (pc),
		.data (instruction)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles) begin
			$display("Timeout: the run exceeded %0d cycles", max_cycles);
			$display("Verification failed");
			$fatal(1, "simulation stopped");
		end
	end

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("Verification failed");
			$fatal(1, "simulation stopped");
		end
	endtask

	task report_failure(input string what);
		$display("Error at %0t: %s", $time, what);
		$display("Verification failed");
		$fatal(1, "simulation stopped");
	endtask

	task wait_ack(input bit spu);
		int n;
		n = 0;
		while ((spu ? spu_hs_ack : spart_hs_ack) !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > 8) report_failure("ack did not rise after a request");
		end
	endtask

	task random_gap(output int cycles);
		cycles = ($unsigned($random(seed)) % 8) + 1;
		repeat (cycles) @(negedge clk);
	endtask

	// Send fetch back to the main loop
	task restart_main;
		@(negedge clk);
		take_branch = 1'b1;
		branch_pc   = main_addr;
		@(negedge clk);
		take_branch = 1'b0;
		check_value("pc", pc, main_addr);
	endtask

	// Branch onto an INTEN word and straight back to the main loop
	task exec_inten(input logic [31:0] addr);
		@(negedge clk);
		take_branch = 1'b1;
		branch_pc   = addr;
		@(negedge clk);
		branch_pc = main_addr;
		@(negedge clk);
		take_branch = 1'b0;
	endtask

	// Starts in the accepting cycle and follows the handler to its return
	task service_check(input logic [31:0] handler, input logic [31:0] reti_addr,
			input logic [31:0] resume_exp, input int start_n, input int branch_at);
		int n;
		int m;
		n = start_n;
		branch_pc = resume_exp;
		while (int_run !== 1'b1) begin
			@(negedge clk);
			n++;
			take_branch = (n == branch_at);
			if (n > FILL_CYCLES + 8) report_failure("int_run never pulsed after accept");
		end
		take_branch = 1'b0;
		check_value("int_run delay", 32'(n), 32'(FILL_CYCLES + 3));
		@(negedge clk);
		check_value("pc", pc, handler);
		check_value("pc_resume", pc_resume, resume_exp);
		m = 0;
		while (pc !== reti_addr) begin
			@(negedge clk);
			m++;
			if (m > 64) report_failure("handler never reached its RETI");
		end
		check_value("int_wait", int_wait, 1'b1);
		m = 0;
		while (int_done !== 1'b1) begin
			@(negedge clk);
			m++;
			if (m > DRAIN_CYCLES + 8) report_failure("int_done never pulsed after RETI");
		end
		check_value("int_done delay", 32'(m), 32'(DRAIN_CYCLES + 1));
		@(negedge clk);
		check_value("pc", pc, resume_exp);
	endtask

	task reset_vectoring;
		rst = 1'b1;
		repeat (10) @(negedge clk);
		check_value("int_wait", int_wait, 1'b1);
		check_value("int_run", int_run, 1'b0);
		check_value("int_done", int_done, 1'b0);
		rst = 1'b0;
		@(negedge clk);
		check_value("pc", pc, 32'h0);
		check_value("int_run", int_run, 1'b0);
		@(negedge clk);
		check_value("int_run", int_run, 1'b1);
		@(negedge clk);
		check_value("pc", pc, main_addr);
	endtask

	task spart_interrupt;
		int gap;
		restart_main();
		random_gap(gap);
		spart_hs_req = 1'b1;
		wait_ack(1'b0);
		check_value("int_wait", int_wait, 1'b1);
		// Fetch advanced one word per cycle from main until the accept stalled it
		resume_a = main_addr + 32'(4 * (gap + 1));
		check_value("pc", pc, resume_a);
		spart_hs_req = 1'b0;
		@(negedge clk);
		check_value("spart_hs_ack", spart_hs_ack, 1'b0);
		service_check(spart_isr, spart_reti, resume_a, 1, 0);
	endtask

	task source_priority;
		int gap;
		restart_main();
		random_gap(gap);
		spart_hs_req = 1'b1;
		spu_hs_req   = 1'b1;
		wait_ack(1'b0);
		check_value("spu_hs_ack", spu_hs_ack, 1'b1);
		check_value("int_wait", int_wait, 1'b1);
		resume_a = main_addr + 32'(4 * (gap + 1));
		check_value("pc", pc, resume_a);
		spart_hs_req = 1'b0;
		spu_hs_req   = 1'b0;
		service_check(spart_isr, spart_reti, resume_a, 0, 0);
		// SPU is still pending and is accepted right after the return
		check_value("int_wait", int_wait, 1'b1);
		service_check(spu_isr, spu_reti, resume_a, 0, 0);
	endtask

	task spu_masking;
		restart_main();
		exec_inten(mask_spu);
		spu_hs_req = 1'b1;
		wait_ack(1'b1);
		spu_hs_req = 1'b0;
		repeat (20) begin
			@(negedge clk);
			check_value("int_wait", int_wait, 1'b0);
		end
		check_value("spu_hs_ack", spu_hs_ack, 1'b0);
		exec_inten(unmask_all);
		check_value("int_wait", int_wait, 1'b1);
		service_check(spu_isr, spu_reti, main_addr, 0, 0);
	endtask

	task branch_in_wait;
		int gap;
		restart_main();
		random_gap(gap);
		spart_hs_req = 1'b1;
		wait_ack(1'b0);
		check_value("int_wait", int_wait, 1'b1);
		spart_hs_req = 1'b0;
		// Offset 3 from accept is the first fill state
		service_check(spart_isr, spart_reti, branch_dest, 0, 3);
	endtask

	task handshake_protocol;
		restart_main();
		exec_inten(mask_spu);
		spu_hs_req = 1'b1;
		wait_ack(1'b1);
		repeat (5) begin
			@(negedge clk);
			check_value("spu_hs_ack", spu_hs_ack, 1'b1);
			check_value("int_wait", int_wait, 1'b0);
		end
		spu_hs_req = 1'b0;
		@(negedge clk);
		check_value("spu_hs_ack", spu_hs_ack, 1'b0);
		// Second request merges into the pending one
		spu_hs_req = 1'b1;
		wait_ack(1'b1);
		spu_hs_req = 1'b0;
		@(negedge clk);
		check_value("spu_hs_ack", spu_hs_ack, 1'b0);
		exec_inten(unmask_all);
		check_value("int_wait", int_wait, 1'b1);
		service_check(spu_isr, spu_reti, main_addr, 0, 0);
		repeat (20) begin
			@(negedge clk);
			check_value("int_run", int_run, 1'b0);
			check_value("int_wait", int_wait, 1'b0);
		end
	endtask

	initial begin
		seed         = 43;
		clk          = 1'b0;
		rst          = 1'b1;
		cycle_cnt    = 0;
		spart_hs_req = 1'b0;
		spu_hs_req   = 1'b0;
		take_branch  = 1'b0;
		branch_pc    = 32'h0;
		i_imem.fill_nops();
		i_imem.write_word(32'h0, main_addr);
		i_imem.write_word(32'h4, spu_isr);
		i_imem.write_word(32'h8, spart_isr);
		// INTEN words with bit 2 for SPART and bit 1 for SPU
		i_imem.write_word(mask_spu, 32'hFC00_0004);
		i_imem.write_word(unmask_all, 32'hFC00_0006);
		i_imem.write_word(spart_reti, 32'hF800_0000);
		i_imem.write_word(spu_reti, 32'hF800_0000);
		reset_vectoring();
		spart_interrupt();
		source_priority();
		spu_masking();
		branch_in_wait();
		handshake_protocol();
		$display("Verification passed");
		$finish;
	end

endmodule

//--- vlog.f
hdl/intc_pkg.sv
hdl/int_source_reg.sv
hdl/int_sequencer.sv
hdl/fetch_pc.sv
hdl/intc_top.sv
test/imem_model.sv
test/tb_intc.sv
